// File: design/cmd_dispatch.sv
/* host must wait for busy low before the next opcode; no queueing of commands
   bytes outside an active command's byte count are dropped by the handlers */
`timescale 1ns/100ps

module cmd_dispatch (
    input  logic              clk,
    input  logic              reset,
    input  fb_mem_pkg::byte_t data_in,
    input  logic              data_valid,
    input  logic              write_done,
    input  logic              read_done,
    output logic              write_byte_strobe,
    output logic              read_byte_strobe,
    output logic              busy,
    output logic              cmd_error
);
    import fb_cmd_pkg::*;

    dispatch_state_t state;
    opcode_t         opcode;

    assign opcode = opcode_t'(data_in); // only meaningful in idle

    // byte strobes follow data_valid while a handler owns the stream
    assign write_byte_strobe = data_valid && (state == DS_WRITING);
    assign read_byte_strobe  = data_valid && (state == DS_READING);
    assign busy              = (state != DS_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= DS_IDLE;
            cmd_error <= 1'b0;
        end else begin
            cmd_error <= 1'b0; // single cycle pulse
            case (state)
                DS_IDLE: begin
                    if (data_valid) begin
                        case (opcode)
                            OP_WRITE_PIXEL: state <= DS_WRITING;
                            OP_READ_PIXEL:  state <= DS_READING;
                            default:        cmd_error <= 1'b1; // stay idle
                        endcase
                    end
                end
                DS_WRITING: begin
                    if (write_done) begin
                        state <= DS_IDLE;
                    end
                end
                DS_READING: begin
                    if (read_done) begin
                        state <= DS_IDLE;
                    end
                end
                default: state <= DS_IDLE;
            endcase
        end
    end

endmodule

// File: design/cmd_pixel_read.sv
/* after the last column byte the pixel bytes go out msb first at one every 2 cycles
   tx has no back-pressure; done coincides with the last tx_valid */
`timescale 1ns/100ps
`include "pixel_engine_config.svh"

module cmd_pixel_read (
    input  logic                   clk,
    input  logic                   reset,
    input  fb_mem_pkg::byte_t      data_in,
    input  logic                   enable,
    input  fb_mem_pkg::byte_t      rd_data,
    input  logic                   rd_valid,
    output fb_mem_pkg::row_t       rd_row,
    output fb_mem_pkg::column_t    rd_column,
    output fb_mem_pkg::pixel_sel_t rd_pixel,
    output logic                   rd_access_start,
    output fb_mem_pkg::byte_t      tx_data,
    output logic                   tx_valid,
    output logic                   done
);
    import fb_cmd_pkg::*;
    import fb_mem_pkg::*;

    read_state_t   state;
    column_buf_t   column_buf;
    column_count_t column_count;

    assign rd_column = column_buf[`PE_COLUMN_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= RD_ROW;
            rd_row          <= '0;
            column_buf      <= '0;
            column_count    <= '0;
            rd_pixel        <= '0;
            rd_access_start <= 1'b0;
            tx_valid        <= 1'b0;
            done            <= 1'b0;
        end else begin
            tx_valid <= 1'b0;
            done     <= 1'b0;
            case (state)
                RD_ROW: begin
                    if (enable) begin
                        rd_row       <= data_in[`PE_ROW_BITS-1:0];
                        column_count <= COLUMN_TOP;
                        state        <= RD_COLUMN;
                    end
                end
                RD_COLUMN: begin
                    if (enable) begin
                        column_buf <= {data_in, column_buf[`PE_COLUMN_BYTES*8-1:8]};
                        if (column_count == '0) begin
                            // first request goes out with the final column byte
                            rd_pixel        <= PIXEL_TOP;
                            rd_access_start <= ~rd_access_start;
                            state           <= RD_WAIT;
                        end else begin
                            column_count <= column_count - 1'b1;
                        end
                    end
                end
                RD_WAIT: state <= RD_FETCH; // ram registers rd_data here
                RD_FETCH: begin
                    if (rd_valid) begin
                        tx_data  <= rd_data;
                        tx_valid <= 1'b1;
                        if (rd_pixel == '0) begin
                            done  <= 1'b1;
                            state <= RD_DONE;
                        end else begin
                            rd_pixel        <= rd_pixel - 1'b1;
                            rd_access_start <= ~rd_access_start; // next byte down
                            state           <= RD_WAIT;
                        end
                    end
                end
                RD_DONE: begin
                    rd_row     <= '0;
                    column_buf <= '0;
                    rd_pixel   <= '0;
                    state      <= RD_ROW;
                end
                default: state <= RD_ROW;
            endcase
        end
    end

endmodule

// File: design/cmd_pixel_write.sv
/* bytes arrive as row, column lsb first, then pixel msb first; the ram write lands one cycle
   after each pixel byte, so row/column/pixel hold until the done cycle ends */
`timescale 1ns/100ps
`include "pixel_engine_config.svh"

module cmd_pixel_write (
    input  logic                   clk,
    input  logic                   reset,
    input  fb_mem_pkg::byte_t      data_in,
    input  logic                   enable,
    output fb_mem_pkg::row_t       row,
    output fb_mem_pkg::column_t    column,
    output fb_mem_pkg::pixel_sel_t pixel,
    output fb_mem_pkg::byte_t      data_out,
    output logic                   ram_write_enable,
    output logic                   ram_access_start,
    output logic                   done
);
    import fb_cmd_pkg::*;
    import fb_mem_pkg::*;

    write_state_t  state;
    column_buf_t   column_buf;
    column_count_t column_count;
    pixel_sel_t    pixel_count; // index of the next byte to arrive

    assign column = column_buf[`PE_COLUMN_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= WR_ROW;
            row              <= '0;
            column_buf       <= '0;
            column_count     <= '0;
            pixel            <= '0;
            pixel_count      <= '0;
            ram_write_enable <= 1'b0;
            ram_access_start <= 1'b0;
            done             <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                WR_ROW: begin
                    if (enable) begin
                        row          <= data_in[`PE_ROW_BITS-1:0];
                        column_count <= COLUMN_TOP;
                        state        <= WR_COLUMN;
                    end
                end
                WR_COLUMN: begin
                    if (enable) begin
                        // shift in from the top so the first byte ends up lowest
                        column_buf <= {data_in, column_buf[`PE_COLUMN_BYTES*8-1:8]};
                        if (column_count == '0) begin
                            pixel_count      <= PIXEL_TOP;
                            ram_write_enable <= 1'b1;
                            state            <= WR_PIXEL_BYTES;
                        end else begin
                            column_count <= column_count - 1'b1;
                        end
                    end
                end
                WR_PIXEL_BYTES: begin
                    if (enable) begin
                        data_out         <= data_in;
                        pixel            <= pixel_count;
                        ram_access_start <= ~ram_access_start; // ram writes next edge
                        if (pixel_count == '0) begin
                            done  <= 1'b1;
                            state <= WR_DONE;
                        end else begin
                            pixel_count <= pixel_count - 1'b1;
                        end
                    end
                end
                WR_DONE: begin
                    // last byte is written at this edge from the old values
                    row              <= '0;
                    column_buf       <= '0;
                    pixel            <= '0;
                    pixel_count      <= '0;
                    ram_write_enable <= 1'b0;
                    state            <= WR_ROW;
                end
                default: state <= WR_ROW;
            endcase
        end
    end

endmodule

// File: design/fb_cmd_pkg.sv
/* host command opcodes and the FSM state encodings of the dispatcher and handlers
   opcodes other than the two listed are rejected by the dispatcher */
package fb_cmd_pkg;

    typedef enum logic [7:0] {
        OP_WRITE_PIXEL = 8'h01,
        OP_READ_PIXEL  = 8'h02
    } opcode_t;

    typedef enum logic [1:0] {
        DS_IDLE,
        DS_WRITING,
        DS_READING
    } dispatch_state_t;

    typedef enum logic [1:0] {
        WR_ROW,
        WR_COLUMN,
        WR_PIXEL_BYTES,
        WR_DONE
    } write_state_t;

    typedef enum logic [2:0] {
        RD_ROW,
        RD_COLUMN,
        RD_WAIT,  // ram latency cycle
        RD_FETCH, // waiting on rd_valid
        RD_DONE
    } read_state_t;

endpackage

// File: design/fb_mem_pkg.sv
/* framebuffer address and data types, sized from the config header */
`include "pixel_engine_config.svh"

package fb_mem_pkg;

    typedef logic [7:0] byte_t;

    typedef logic [`PE_ROW_BITS-1:0] row_t;
    typedef logic [`PE_COLUMN_BITS-1:0] column_t;
    typedef logic [`PE_PIXEL_SEL_BITS-1:0] pixel_sel_t;

    // raw column bytes as they arrive, upper bits beyond the column are dropped
    typedef logic [`PE_COLUMN_BYTES*8-1:0] column_buf_t;

    // counts the remaining column bytes
    typedef logic [$clog2(`PE_COLUMN_BYTES)-1:0] column_count_t;

    // index of the top byte of a pixel, sent first
    localparam pixel_sel_t PIXEL_TOP = pixel_sel_t'(`PE_BYTES_PER_PIXEL - 1);

    localparam column_count_t COLUMN_TOP = column_count_t'(`PE_COLUMN_BYTES - 1);

endpackage

// File: design/frame_ram.sv
/* access starts on any change of a toggle line; one cycle latency on both ports
   contents are undefined until written */
`timescale 1ns/100ps
`include "pixel_engine_config.svh"

module frame_ram (
    input  logic                   clk,
    input  logic                   reset,
    input  fb_mem_pkg::row_t       wr_row,
    input  fb_mem_pkg::column_t    wr_column,
    input  fb_mem_pkg::pixel_sel_t wr_pixel,
    input  fb_mem_pkg::byte_t      wr_data,
    input  logic                   wr_enable,
    input  logic                   wr_access_start,
    input  fb_mem_pkg::row_t       rd_row,
    input  fb_mem_pkg::column_t    rd_column,
    input  fb_mem_pkg::pixel_sel_t rd_pixel,
    input  logic                   rd_access_start,
    output fb_mem_pkg::byte_t      rd_data,
    output logic                   rd_valid
);
    import fb_mem_pkg::*;

    byte_t mem [`PE_RAM_DEPTH];

    logic wr_toggle_q;
    logic rd_toggle_q;
    logic wr_fire;
    logic rd_fire;

    assign wr_fire = (wr_access_start != wr_toggle_q) && wr_enable;
    assign rd_fire = (rd_access_start != rd_toggle_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_toggle_q <= 1'b0;
            rd_toggle_q <= 1'b0;
            rd_valid    <= 1'b0;
        end else begin
            wr_toggle_q <= wr_access_start;
            rd_toggle_q <= rd_access_start;
            rd_valid    <= rd_fire;
        end
    end

    // storage addressed by {row, column, pixel}
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[{wr_row, wr_column, wr_pixel}] <= wr_data;
        end
        if (rd_fire) begin
            rd_data <= mem[{rd_row, rd_column, rd_pixel}];
        end
    end

endmodule

// File: design/pixel_engine_config.svh
/* fixed framebuffer geometry; PE_COLUMN_BYTES must be at least 2 and cover PE_COLUMN_BITS
   PE_PIXEL_SEL_BITS must be wide enough to index PE_BYTES_PER_PIXEL bytes */
`ifndef PIXEL_ENGINE_CONFIG_SVH
`define PIXEL_ENGINE_CONFIG_SVH

// address geometry
`define PE_ROW_BITS 5
`define PE_COLUMN_BITS 9
`define PE_COLUMN_BYTES 2 // column sent little-endian

// pixel storage
`define PE_BYTES_PER_PIXEL 2
`define PE_PIXEL_SEL_BITS 1

// one byte per {row, column, pixel} address
`define PE_RAM_DEPTH (1 << (`PE_ROW_BITS + `PE_COLUMN_BITS + `PE_PIXEL_SEL_BITS))

`endif

// File: design/pixel_engine_top.sv
/* byte-serial framebuffer engine; host waits for busy low between commands
   unknown opcodes only pulse cmd_error */
`timescale 1ns/100ps

module pixel_engine_top (
    input  logic              clk,
    input  logic              reset,
    input  fb_mem_pkg::byte_t data_in,
    input  logic              data_valid,
    output fb_mem_pkg::byte_t tx_data,
    output logic              tx_valid,
    output logic              busy,
    output logic              cmd_error
);
    import fb_mem_pkg::*;

    logic write_byte_strobe;
    logic read_byte_strobe;
    logic write_done;
    logic read_done;

    // write handler to ram
    row_t       wr_row;
    column_t    wr_column;
    pixel_sel_t wr_pixel;
    byte_t      wr_data;
    logic       wr_enable;
    logic       wr_access_start;

    // read handler to ram and back
    row_t       rd_row;
    column_t    rd_column;
    pixel_sel_t rd_pixel;
    logic       rd_access_start;
    byte_t      rd_data;
    logic       rd_valid;

    cmd_dispatch i_cmd_dispatch (
        .clk               (clk),
        .reset             (reset),
        .data_in           (data_in),
        .data_valid        (data_valid),
        .write_done        (write_done),
        .read_done         (read_done),
        .write_byte_strobe (write_byte_strobe),
        .read_byte_strobe  (read_byte_strobe),
        .busy              (busy),
        .cmd_error         (cmd_error)
    );

    cmd_pixel_write i_cmd_pixel_write (
        .clk              (clk),
        .reset            (reset),
        .data_in          (data_in),
        .enable           (write_byte_strobe),
        .row              (wr_row),
        .column           (wr_column),
        .pixel            (wr_pixel),
        .data_out         (wr_data),
        .ram_write_enable (wr_enable),
        .ram_access_start (wr_access_start),
        .done             (write_done)
    );

    cmd_pixel_read i_cmd_pixel_read (
        .clk             (clk),
        .reset           (reset),
        .data_in         (data_in),
        .enable          (read_byte_strobe),
        .rd_data         (rd_data),
        .rd_valid        (rd_valid),
        .rd_row          (rd_row),
        .rd_column       (rd_column),
        .rd_pixel        (rd_pixel),
        .rd_access_start (rd_access_start),
        .tx_data         (tx_data),
        .tx_valid        (tx_valid),
        .done            (read_done)
    );

    frame_ram i_frame_ram (
        .clk             (clk),
        .reset           (reset),
        .wr_row          (wr_row),
        .wr_column       (wr_column),
        .wr_pixel        (wr_pixel),
        .wr_data         (wr_data),
        .wr_enable       (wr_enable),
        .wr_access_start (wr_access_start),
        .rd_row          (rd_row),
        .rd_column       (rd_column),
        .rd_pixel        (rd_pixel),
        .rd_access_start (rd_access_start),
        .rd_data         (rd_data),
        .rd_valid        (rd_valid)
    );

endmodule

// File: pixel_engine.f
+incdir+design
design/fb_cmd_pkg.sv
design/fb_mem_pkg.sv
design/cmd_dispatch.sv
design/cmd_pixel_write.sv
design/cmd_pixel_read.sv
design/frame_ram.sv
design/pixel_engine_top.sv
testbench/tb_pixel_engine.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pixel engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f pixel_engine.f --top-module tb_pixel_engine \
    -o sim_pixel_engine

./obj_dir/sim_pixel_engine > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
grep -q "=== PASS ===" sim.log

// File: testbench/tb_pixel_engine.sv
/* drives whole host commands and waits for busy low between them
   pixel bytes are checked in tx order against a model of every write */
`timescale 1ns/100ps
`include "pixel_engine_config.svh"

module tb_pixel_engine;
    import fb_cmd_pkg::*;
    import fb_mem_pkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int RANDOM_WRITES = 200;
    localparam int ADDR_BITS     = `PE_ROW_BITS + `PE_COLUMN_BITS;
    localparam int PIXEL_BITS    = `PE_BYTES_PER_PIXEL * 8;
    localparam int IDLE_LIMIT    = 60; // cycles a single command may keep busy high
    // writes, reads and the unknown opcode of all tests
    localparam int NUM_COMMANDS  = 2 + 4 + 2 * RANDOM_WRITES + 4 + 1;
    localparam int CYCLE_LIMIT   = 40 * NUM_COMMANDS + RESET_CYCLES;

    logic  clk;
    logic  reset;
    byte_t data_in;
    logic  data_valid;
    byte_t tx_data;
    logic  tx_valid;
    logic  busy;
    logic  cmd_error;

    byte_t model [`PE_RAM_DEPTH];  // expected frame contents
    bit    pixel_written [1 << ADDR_BITS];
    logic [ADDR_BITS-1:0] addr_q [$]; // distinct random addresses
    byte_t expected_q [$];             // tx bytes still to come

    int error_count;
    int check_count;
    int tx_count;
    int error_pulses;
    int cycle_count;

    pixel_engine_top i_pixel_engine_top (
        .clk        (clk),
        .reset      (reset),
        .data_in    (data_in),
        .data_valid (data_valid),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .busy       (busy),
        .cmd_error  (cmd_error)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic byte_t expected_byte(row_t row, column_t column, pixel_sel_t index);
        return model[{row, column, index}];
    endfunction

    task automatic check_byte(string name, byte_t actual, byte_t expected);
        check_count++;
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %02h, expected %02h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        check_count++;
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic report_test(string name, int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // one strobed byte, then a quiet cycle
    task automatic send_byte(byte_t value);
        @(posedge clk);
        data_in    <= value;
        data_valid <= 1'b1;
        @(posedge clk);
        data_valid <= 1'b0;
    endtask

    task automatic send_address(row_t row, column_t column);
        byte_t                        row_byte;
        logic [`PE_COLUMN_BYTES*8-1:0] column_wide;
        row_byte = '0;
        row_byte[`PE_ROW_BITS-1:0] = row;
        column_wide = '0;
        column_wide[`PE_COLUMN_BITS-1:0] = column;
        send_byte(row_byte);
        for (int i = 0; i < `PE_COLUMN_BYTES; i++) begin
            send_byte(column_wide[i*8 +: 8]); // low byte first
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (busy && waited < IDLE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            $display("Error at %0t ns: busy still high after %0d cycles", $time, waited);
            error_count++;
        end
    endtask

    task automatic write_pixel(row_t row, column_t column, logic [PIXEL_BITS-1:0] value);
        send_byte(OP_WRITE_PIXEL);
        send_address(row, column);
        for (int i = `PE_BYTES_PER_PIXEL - 1; i >= 0; i--) begin
            send_byte(value[i*8 +: 8]); // top byte first
            model[{row, column, pixel_sel_t'(i)}] = value[i*8 +: 8];
        end
        wait_idle();
    endtask

    task automatic read_pixel(row_t row, column_t column);
        int start_count;
        start_count = tx_count;
        for (int i = `PE_BYTES_PER_PIXEL - 1; i >= 0; i--) begin
            expected_q.push_back(expected_byte(row, column, pixel_sel_t'(i)));
        end
        send_byte(OP_READ_PIXEL);
        send_address(row, column);
        wait_idle();
        if (tx_count - start_count != `PE_BYTES_PER_PIXEL) begin
            $display("Error at %0t ns: read of row %0d column %0d gave %0d tx bytes, expected %0d",
                     $time, row, column, tx_count - start_count, `PE_BYTES_PER_PIXEL);
            error_count++;
        end
        expected_q.delete();
    endtask

    // tx and cmd_error monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (tx_valid) begin
                tx_count++;
                if (expected_q.size() == 0) begin
                    $display("Error at %0t ns: tx byte %02h arrived with none expected",
                             $time, tx_data);
                    error_count++;
                end else begin
                    check_byte("tx_data", tx_data, expected_q.pop_front());
                end
            end
            if (cmd_error) begin
                error_pulses++;
            end
        end
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int                   errors_before;
        int                   pulses_before;
        int                   pulses_seen;
        int                   j;
        logic [31:0]          rnd;
        logic [ADDR_BITS-1:0] pick;
        logic [ADDR_BITS-1:0] swap;

        reset      <= 1'b1;
        data_in    <= '0;
        data_valid <= 1'b0;
        void'($urandom(32'hf817_f3e5));

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        errors_before = error_count;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("tx_valid", tx_valid, 1'b0);
        check_flag("cmd_error", cmd_error, 1'b0);
        report_test("reset state", errors_before);

        errors_before = error_count;
        write_pixel(5'd3, 9'd10, 16'ha55a);
        read_pixel(5'd3, 9'd10);
        report_test("write then read", errors_before);

        // 0x105 must not alias 0x005
        errors_before = error_count;
        write_pixel(5'd7, 9'h105, 16'h1234);
        write_pixel(5'd7, 9'h005, 16'hbeef);
        read_pixel(5'd7, 9'h105);
        read_pixel(5'd7, 9'h005);
        report_test("column above 255", errors_before);

        errors_before = error_count;
        for (int n = 0; n < RANDOM_WRITES; n++) begin
            if (addr_q.size() > 0 && $urandom_range(0, 3) == 0) begin
                pick = addr_q[$urandom_range(0, addr_q.size() - 1)]; // overwrite
            end else begin
                rnd  = $urandom();
                pick = rnd[ADDR_BITS-1:0];
            end
            if (!pixel_written[pick]) begin
                pixel_written[pick] = 1'b1;
                addr_q.push_back(pick);
            end
            rnd = $urandom();
            write_pixel(pick[ADDR_BITS-1 -: `PE_ROW_BITS], pick[`PE_COLUMN_BITS-1:0],
                        rnd[PIXEL_BITS-1:0]);
        end
        for (int n = addr_q.size() - 1; n > 0; n--) begin
            j         = int'($urandom_range(0, n));
            swap      = addr_q[n];
            addr_q[n] = addr_q[j];
            addr_q[j] = swap;
        end
        foreach (addr_q[k]) begin
            read_pixel(addr_q[k][ADDR_BITS-1 -: `PE_ROW_BITS],
                       addr_q[k][`PE_COLUMN_BITS-1:0]);
        end
        report_test("random writes and reads", errors_before);

        errors_before = error_count;
        pulses_before = error_pulses;
        send_byte(8'h7f);
        @(negedge clk);
        check_flag("cmd_error", cmd_error, 1'b1);
        check_flag("busy", busy, 1'b0);
        @(negedge clk);
        check_flag("cmd_error", cmd_error, 1'b0);
        check_flag("busy", busy, 1'b0);
        write_pixel(5'd31, 9'h1ff, 16'h0ff0);
        read_pixel(5'd31, 9'h1ff);
        read_pixel(5'd3, 9'd10); // earlier pixel untouched
        if (error_pulses - pulses_before != 1) begin
            $display("Error at %0t ns: cmd_error pulsed %0d times, expected 1",
                     $time, error_pulses - pulses_before);
            error_count++;
        end
        report_test("unknown opcode", errors_before);

        // count strobes directly, busy must drop one cycle after the last
        errors_before = error_count;
        pulses_seen   = 0;
        for (int i = `PE_BYTES_PER_PIXEL - 1; i >= 0; i--) begin
            expected_q.push_back(expected_byte(5'd7, 9'h105, pixel_sel_t'(i)));
        end
        send_byte(OP_READ_PIXEL);
        send_address(5'd7, 9'h105);
        j = 0;
        while (pulses_seen < `PE_BYTES_PER_PIXEL && j < IDLE_LIMIT) begin
            @(negedge clk);
            if (tx_valid) begin
                pulses_seen++;
            end
            j++;
        end
        if (pulses_seen != `PE_BYTES_PER_PIXEL) begin
            $display("Error at %0t ns: only %0d tx_valid pulses seen, expected %0d",
                     $time, pulses_seen, `PE_BYTES_PER_PIXEL);
            error_count++;
        end
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("tx_valid", tx_valid, 1'b0);
        expected_q.delete();
        report_test("read tx count", errors_before);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
